// File: hdl/cpuIsaPkg.sv
// Instruction-set definitions for the load/store core
// Word type, opcode encoding, instruction field positions, memory and register sizes
package cpuIsaPkg;

    localparam int wordWidth = 32;
    localparam int regCount = 16;
    localparam int regIdxWidth = 4;
    localparam int memWords = 512;
    localparam int memAddrWidth = 9;

    typedef logic [wordWidth-1:0] wordT;

    typedef enum logic [4:0] {
        ld   = 5'd0,
        st   = 5'd1,
        addi = 5'd2,
        add  = 5'd3,
        sub  = 5'd4,
        andOp = 5'd5,
        orOp = 5'd6,
        out  = 5'd7,
        halt = 5'd8
    } opcodeT;

    // Field positions within an instruction word
    localparam int opMsb = 31;
    localparam int opLsb = 27;
    localparam int raMsb = 26;
    localparam int raLsb = 23;
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;
    localparam int cMsb = 18; // C overlaps rc
    localparam int cLsb = 0;

    typedef struct packed {
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic [regIdxWidth-1:0] rc;
    } irFieldsT;

endpackage

// File: hdl/cpuCtrlPkg.sv
// Control-path definitions
// Micro-step enum, ALU operations, control strobe bundle and bus source names
package cpuCtrlPkg;

    typedef enum logic [2:0] {
        T0, T1, T2, T3, T4, T5, T6, T7
    } stepT;

    typedef enum logic [2:0] {
        passY = 3'd0,
        addOp = 3'd1,
        subOp = 3'd2,
        andOp = 3'd3,
        orOp  = 3'd4,
        incPc = 3'd5
    } aluOpT;

    // One strobe set per micro-step
    typedef struct packed {
        logic gra;
        logic grb;
        logic grc;
        logic rIn;
        logic rOut;
        logic baOut;     // Base read, R0 gives zero
        logic pcIn;
        logic pcOut;
        logic marIn;
        logic mdrIn;
        logic mdrOut;
        logic read;
        logic write;
        logic yIn;
        logic zIn;
        logic zLowOut;
        logic cOut;
        logic outPortIn;
        aluOpT aluOp;
    } ctrlSignalsT;

    typedef enum logic [2:0] {
        busNone, busReg, busPc, busMdr, busZ, busC
    } busSrcT;

endpackage

// File: hdl/controlUnit.sv
// Control unit for the bus core
// Instruction register, micro-step counter, run/halt state and strobe decode
`timescale 1ns/100ps
module controlUnit (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    start,
    input  cpuIsaPkg::wordT         bus,
    output cpuCtrlPkg::ctrlSignalsT ctrl,
    output cpuIsaPkg::wordT         cValue,
    output cpuIsaPkg::irFieldsT     irFields,
    output logic                    halted
);

    cpuIsaPkg::wordT         ir;
    cpuCtrlPkg::stepT        step;
    cpuCtrlPkg::ctrlSignalsT ctrlNext;
    cpuIsaPkg::opcodeT       irOp;
    cpuIsaPkg::opcodeT       busOp;
    logic                    running;
    logic                    lastStep;
    logic                    haltStep;

    function automatic cpuCtrlPkg::aluOpT aluOpFor(input cpuIsaPkg::opcodeT op);
        case (op)
            cpuIsaPkg::sub:   return cpuCtrlPkg::subOp;
            cpuIsaPkg::andOp: return cpuCtrlPkg::andOp;
            cpuIsaPkg::orOp:  return cpuCtrlPkg::orOp;
            default:          return cpuCtrlPkg::addOp; // add, addi
        endcase
    endfunction

    assign irOp = cpuIsaPkg::opcodeT'(ir[cpuIsaPkg::opMsb:cpuIsaPkg::opLsb]);
    assign busOp = cpuIsaPkg::opcodeT'(bus[cpuIsaPkg::opMsb:cpuIsaPkg::opLsb]);

    assign cValue = {{(cpuIsaPkg::wordWidth - cpuIsaPkg::cMsb - 1){ir[cpuIsaPkg::cMsb]}},
                     ir[cpuIsaPkg::cMsb:cpuIsaPkg::cLsb]};

    always_comb begin
        irFields.ra = ir[cpuIsaPkg::raMsb:cpuIsaPkg::raLsb];
        irFields.rb = ir[cpuIsaPkg::rbMsb:cpuIsaPkg::rbLsb];
        irFields.rc = ir[cpuIsaPkg::rcMsb:cpuIsaPkg::rcLsb];
    end

    always_comb begin
        ctrlNext = '0;
        lastStep = 1'b0;
        haltStep = 1'b0;
        case (step)
            cpuCtrlPkg::T0: begin // Fetch address, PC+1 into Z
                ctrlNext.pcOut = 1'b1;
                ctrlNext.marIn = 1'b1;
                ctrlNext.zIn = 1'b1;
                ctrlNext.aluOp = cpuCtrlPkg::incPc;
            end
            cpuCtrlPkg::T1: begin
                ctrlNext.zLowOut = 1'b1;
                ctrlNext.pcIn = 1'b1;
                ctrlNext.read = 1'b1;
                ctrlNext.mdrIn = 1'b1;
            end
            cpuCtrlPkg::T2: begin
                ctrlNext.mdrOut = 1'b1; // IR picks this up
                haltStep = (busOp == cpuIsaPkg::halt);
                lastStep = haltStep;
            end
            default: begin
                case (irOp)
                    cpuIsaPkg::ld, cpuIsaPkg::st: begin
                        case (step)
                            cpuCtrlPkg::T3: begin
                                ctrlNext.grb = 1'b1;
                                ctrlNext.baOut = 1'b1;
                                ctrlNext.yIn = 1'b1;
                            end
                            cpuCtrlPkg::T4: begin // Effective address
                                ctrlNext.cOut = 1'b1;
                                ctrlNext.zIn = 1'b1;
                                ctrlNext.aluOp = cpuCtrlPkg::addOp;
                            end
                            cpuCtrlPkg::T5: begin
                                ctrlNext.zLowOut = 1'b1;
                                ctrlNext.marIn = 1'b1;
                            end
                            cpuCtrlPkg::T6: begin
                                ctrlNext.mdrIn = 1'b1;
                                ctrlNext.read = (irOp == cpuIsaPkg::ld);
                                ctrlNext.gra = (irOp == cpuIsaPkg::st);
                                ctrlNext.rOut = (irOp == cpuIsaPkg::st);
                            end
                            default: begin
                                ctrlNext.mdrOut = (irOp == cpuIsaPkg::ld);
                                ctrlNext.gra = (irOp == cpuIsaPkg::ld);
                                ctrlNext.rIn = (irOp == cpuIsaPkg::ld);
                                ctrlNext.write = (irOp == cpuIsaPkg::st);
                                lastStep = 1'b1;
                            end
                        endcase
                    end
                    cpuIsaPkg::addi, cpuIsaPkg::add, cpuIsaPkg::sub,
                    cpuIsaPkg::andOp, cpuIsaPkg::orOp: begin
                        case (step)
                            cpuCtrlPkg::T3: begin
                                ctrlNext.grb = 1'b1;
                                ctrlNext.rOut = 1'b1;
                                ctrlNext.yIn = 1'b1;
                            end
                            cpuCtrlPkg::T4: begin
                                ctrlNext.cOut = (irOp == cpuIsaPkg::addi);
                                ctrlNext.grc = (irOp != cpuIsaPkg::addi);
                                ctrlNext.rOut = (irOp != cpuIsaPkg::addi);
                                ctrlNext.zIn = 1'b1;
                                ctrlNext.aluOp = aluOpFor(irOp);
                            end
                            default: begin // Write back
                                ctrlNext.zLowOut = 1'b1;
                                ctrlNext.gra = 1'b1;
                                ctrlNext.rIn = 1'b1;
                                lastStep = 1'b1;
                            end
                        endcase
                    end
                    cpuIsaPkg::out: begin
                        ctrlNext.gra = 1'b1;
                        ctrlNext.rOut = 1'b1;
                        ctrlNext.outPortIn = 1'b1;
                        lastStep = 1'b1;
                    end
                    default: lastStep = 1'b1; // Unused opcode acts as a no-op
                endcase
            end
        endcase
    end

    assign ctrl = running ? ctrlNext : '0;
    assign halted = !running;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            step <= cpuCtrlPkg::T0;
        end else if (!running) begin
            if (start) begin
                running <= 1'b1;
                step <= cpuCtrlPkg::T0;
            end
        end else begin
            step <= lastStep ? cpuCtrlPkg::T0 : cpuCtrlPkg::stepT'(step + 3'd1);
            if (haltStep)
                running <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (running && step == cpuCtrlPkg::T2)
            ir <= bus;
    end

endmodule

// File: hdl/registerFile.sv
// General register file and program counter
// Gra/Grb/Grc index select, base-address read with R0 as zero
`timescale 1ns/100ps
module registerFile (
    input  logic                    clk,
    input  logic                    rstN,
    input  cpuCtrlPkg::ctrlSignalsT ctrl,
    input  cpuIsaPkg::irFieldsT     irFields,
    input  logic                    start,
    input  cpuIsaPkg::wordT         bus,
    output cpuIsaPkg::wordT         regData,
    output cpuIsaPkg::wordT         pcData
);

    cpuIsaPkg::wordT                   regs [cpuIsaPkg::regCount];
    cpuIsaPkg::wordT                   pc;
    logic [cpuIsaPkg::regIdxWidth-1:0] regIdx;

    always_comb begin
        if (ctrl.gra)
            regIdx = irFields.ra;
        else if (ctrl.grb)
            regIdx = irFields.rb;
        else if (ctrl.grc)
            regIdx = irFields.rc;
        else
            regIdx = '0; // No register selected
    end

    // Zero only for a base read of R0
    assign regData = (ctrl.baOut && regIdx == '0) ? '0 : regs[regIdx];
    assign pcData = pc;

    always_ff @(posedge clk) begin
        if (ctrl.rIn)
            regs[regIdx] <= bus;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            pc <= '0;
        else if (start)
            pc <= '0; // Program always starts at word 0
        else if (ctrl.pcIn)
            pc <= bus;
    end

endmodule

// File: hdl/aluUnit.sv
// ALU with its operand and result registers
// Y holds the first operand, the bus gives the second, Z keeps the result
`timescale 1ns/100ps
module aluUnit (
    input  logic                    clk,
    input  logic                    rstN,
    input  cpuCtrlPkg::ctrlSignalsT ctrl,
    input  cpuIsaPkg::wordT         bus,
    output cpuIsaPkg::wordT         zData
);

    cpuIsaPkg::wordT y;
    cpuIsaPkg::wordT z;
    cpuIsaPkg::wordT result;

    always_comb begin
        case (ctrl.aluOp)
            cpuCtrlPkg::addOp: begin
                result = y + bus;
            end
            cpuCtrlPkg::subOp: begin
                result = y - bus;
            end
            cpuCtrlPkg::andOp: begin
                result = y & bus;
            end
            cpuCtrlPkg::orOp: begin
                result = y | bus;
            end
            cpuCtrlPkg::incPc: begin
                // Bus carries PC during T0, Y not involved
                result = bus + cpuIsaPkg::wordT'(1);
            end
            default: begin
                result = y;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            y <= '0;
        end else if (ctrl.yIn) begin
            y <= bus;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            z <= '0;
        end else if (ctrl.zIn) begin
            z <= result;
        end
    end

    assign zData = z; // Single word, so Z low is all of Z

endmodule

// File: hdl/memoryInterface.sv
// Memory side of the datapath
// MAR, MDR and the 512-word RAM with a host load and inspect port
`timescale 1ns/100ps
module memoryInterface (
    input  logic                             clk,
    input  logic                             rstN,
    input  cpuCtrlPkg::ctrlSignalsT          ctrl,
    input  cpuIsaPkg::wordT                  bus,
    output cpuIsaPkg::wordT                  mdrData,
    input  logic                             hostWrEn,
    input  logic [cpuIsaPkg::memAddrWidth-1:0] hostAddr,
    input  cpuIsaPkg::wordT                  hostData,
    output cpuIsaPkg::wordT                  hostRdData
);

    cpuIsaPkg::wordT                     mem [cpuIsaPkg::memWords];
    logic [cpuIsaPkg::memAddrWidth-1:0]  mar;
    cpuIsaPkg::wordT                     mdr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (ctrl.marIn)
                mar <= bus[cpuIsaPkg::memAddrWidth-1:0]; // Upper bits ignored
            if (ctrl.mdrIn)
                mdr <= ctrl.read ? mem[mar] : bus;
        end
    end

    // Core write first, host only loads while halted
    always_ff @(posedge clk) begin
        if (ctrl.write)
            mem[mar] <= mdr;
        else if (hostWrEn)
            mem[hostAddr] <= hostData;
    end

    assign mdrData = mdr;
    assign hostRdData = mem[hostAddr];

endmodule

// File: hdl/cpuTop.sv
// Top level of the bus core
// Shared bus multiplexer, output port register and the block instances
`timescale 1ns/100ps
module cpuTop (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               start,
    input  logic                               hostWrEn,
    input  logic [cpuIsaPkg::memAddrWidth-1:0] hostAddr,
    input  cpuIsaPkg::wordT                    hostData,
    output cpuIsaPkg::wordT                    hostRdData,
    output cpuIsaPkg::wordT                    outPort,
    output logic                               outValid,
    output logic                               halted
);

    cpuCtrlPkg::ctrlSignalsT ctrl;
    cpuCtrlPkg::busSrcT      busSrc;
    cpuIsaPkg::irFieldsT     irFields;
    cpuIsaPkg::wordT         bus;
    cpuIsaPkg::wordT         cValue;
    cpuIsaPkg::wordT         regData;
    cpuIsaPkg::wordT         pcData;
    cpuIsaPkg::wordT         zData;
    cpuIsaPkg::wordT         mdrData;

    always_comb begin
        if (ctrl.rOut || ctrl.baOut)
            busSrc = cpuCtrlPkg::busReg;
        else if (ctrl.pcOut)
            busSrc = cpuCtrlPkg::busPc;
        else if (ctrl.mdrOut)
            busSrc = cpuCtrlPkg::busMdr;
        else if (ctrl.zLowOut)
            busSrc = cpuCtrlPkg::busZ;
        else if (ctrl.cOut)
            busSrc = cpuCtrlPkg::busC;
        else
            busSrc = cpuCtrlPkg::busNone;
    end

    always_comb begin
        case (busSrc)
            cpuCtrlPkg::busReg: bus = regData;
            cpuCtrlPkg::busPc:  bus = pcData;
            cpuCtrlPkg::busMdr: bus = mdrData;
            cpuCtrlPkg::busZ:   bus = zData;
            cpuCtrlPkg::busC:   bus = cValue;
            default:            bus = '0; // Idle bus
        endcase
    end

    // Output port, valid follows the load by one cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outPort <= '0;
            outValid <= 1'b0;
        end else begin
            if (ctrl.outPortIn)
                outPort <= bus;
            outValid <= ctrl.outPortIn;
        end
    end

    controlUnit i_controlUnit (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .bus      (bus),
        .ctrl     (ctrl),
        .cValue   (cValue),
        .irFields (irFields),
        .halted   (halted)
    );

    registerFile i_registerFile (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .irFields (irFields),
        .start    (start && halted), // Ignored while running
        .bus      (bus),
        .regData  (regData),
        .pcData   (pcData)
    );

    aluUnit i_aluUnit (
        .clk   (clk),
        .rstN  (rstN),
        .ctrl  (ctrl),
        .bus   (bus),
        .zData (zData)
    );

    memoryInterface i_memoryInterface (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (ctrl),
        .bus        (bus),
        .mdrData    (mdrData),
        .hostWrEn   (hostWrEn),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .hostRdData (hostRdData)
    );

endmodule

// File: verification/cpuRefModel.svh
// Reference side of the core testbench
// LFSR random source, instruction encoders and an instruction-level model
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

logic [31:0]     lfsrState = 32'haabd371b;
cpuIsaPkg::wordT modelMem [cpuIsaPkg::memWords];
cpuIsaPkg::wordT expOuts [$]; // Out values of one model run

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic cpuIsaPkg::wordT nextRandom(input int bits);
    cpuIsaPkg::wordT value;
    value = '0;
    for (int i = 0; i < bits; i++) begin
        lfsrState = {lfsrState[30:0], lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
        value = {value[30:0], lfsrState[0]};
    end
    return value;
endfunction

function automatic cpuIsaPkg::wordT instrImm(input cpuIsaPkg::opcodeT op, input int ra,
                                             input int rb, input int c);
    return {op, ra[3:0], rb[3:0], c[18:0]};
endfunction

function automatic cpuIsaPkg::wordT instrReg(input cpuIsaPkg::opcodeT op, input int ra,
                                             input int rb, input int rc);
    return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
endfunction

// Runs modelMem in place, fills expOuts, returns the clock count
function automatic int refRun();
    cpuIsaPkg::wordT regs [cpuIsaPkg::regCount];
    cpuIsaPkg::wordT pc;
    cpuIsaPkg::wordT instr;
    cpuIsaPkg::wordT c;
    cpuIsaPkg::wordT addr;
    logic [3:0]      ra;
    logic [3:0]      rb;
    logic [3:0]      rc;
    int              cycles;
    bit              running;
    foreach (regs[i])
        regs[i] = '0;
    expOuts.delete();
    pc = '0;
    cycles = 0;
    running = 1'b1;
    while (running && cycles < 100000) begin // Guard against a runaway program
        instr = modelMem[pc[8:0]];
        pc = pc + 1;
        ra = instr[26:23];
        rb = instr[22:19];
        rc = instr[18:15];
        c = {{13{instr[18]}}, instr[18:0]};
        addr = ((rb == 4'd0) ? '0 : regs[rb]) + c; // Base of R0 means absolute
        case (cpuIsaPkg::opcodeT'(instr[31:27]))
            cpuIsaPkg::ld: begin
                regs[ra] = modelMem[addr[8:0]];
                cycles += 8;
            end
            cpuIsaPkg::st: begin
                modelMem[addr[8:0]] = regs[ra];
                cycles += 8;
            end
            cpuIsaPkg::addi: begin
                regs[ra] = regs[rb] + c; // R0 as a source is a normal register here
                cycles += 6;
            end
            cpuIsaPkg::add: begin
                regs[ra] = regs[rb] + regs[rc];
                cycles += 6;
            end
            cpuIsaPkg::sub: begin
                regs[ra] = regs[rb] - regs[rc];
                cycles += 6;
            end
            cpuIsaPkg::andOp: begin
                regs[ra] = regs[rb] & regs[rc];
                cycles += 6;
            end
            cpuIsaPkg::orOp: begin
                regs[ra] = regs[rb] | regs[rc];
                cycles += 6;
            end
            cpuIsaPkg::out: begin
                expOuts.push_back(regs[ra]);
                cycles += 4;
            end
            default: begin // halt
                running = 1'b0;
                cycles += 3;
            end
        endcase
    end
    return cycles;
endfunction

`endif

// File: verification/cpuTb.sv
// Testbench for the load/store bus core
// Program build and host load, run with cycle check, output comparison, timeout
`timescale 1ns/100ps
module cpuTb;

    logic                               clk = 1'b0;
    logic                               rstN;
    logic                               start;
    logic                               hostWrEn;
    logic [cpuIsaPkg::memAddrWidth-1:0] hostAddr;
    cpuIsaPkg::wordT                    hostData;
    cpuIsaPkg::wordT                    hostRdData;
    cpuIsaPkg::wordT                    outPort;
    logic                               outValid;
    logic                               halted;

    cpuIsaPkg::wordT image [cpuIsaPkg::memWords]; // Next memory image to load
    cpuIsaPkg::wordT expQueue [$];                 // All expected out values so far
    int              progLen;
    int              outIdx = 0;
    int              cycleCount = 0;
    int              cycleLimit = 40; // Reset plus margin, grows per program
    logic            started = 1'b0;
    logic            lastValid = 1'b0;

    `include "cpuRefModel.svh"

    cpuTop i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .hostWrEn   (hostWrEn),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .hostRdData (hostRdData),
        .outPort    (outPort),
        .outValid   (outValid),
        .halted     (halted)
    );

    always #4 clk = ~clk;

    task automatic finishWithFailure(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Output checker, one value per outValid pulse
    always @(negedge clk) begin
        if (rstN && outValid) begin
            assert (started)
                else finishWithFailure("outValid pulsed before the first start");
            assert (!lastValid)
                else finishWithFailure("outValid stayed high for more than one cycle");
            assert (outIdx < expQueue.size())
                else finishWithFailure("The core produced more out values than the model");
            assert (outPort === expQueue[outIdx])
                else finishWithFailure($sformatf("FAIL %0t: outPort 0x%08h, expected 0x%08h (value %0d)",
                                                 $time, outPort, expQueue[outIdx], outIdx));
            outIdx++;
        end
        lastValid = outValid;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit)
            finishWithFailure($sformatf("Timeout, the run did not finish within %0d clock cycles",
                                        cycleLimit));
    end

    task automatic clearImage();
        for (int a = 0; a < cpuIsaPkg::memWords; a++)
            image[a] = {7'h55, 9'(a), 7'h2a, ~9'(a)}; // Fill depends on every address bit
        progLen = 0;
    endtask

    task automatic emit(input cpuIsaPkg::wordT word);
        image[progLen] = word;
        progLen++;
    endtask

    // addi with random constants from a zero register, then out of every register
    task automatic buildAddiProgram();
        clearImage();
        image[256] = '0;
        emit(instrImm(cpuIsaPkg::ld, 15, 0, 256));
        for (int i = 0; i < 16; i++)
            emit(instrImm(cpuIsaPkg::addi, i, 15, nextRandom(19))); // R15 stays 0 until last
        for (int k = 0; k < 8; k++)
            emit(instrImm(cpuIsaPkg::addi, nextRandom(4), nextRandom(4), nextRandom(19)));
        for (int i = 0; i < 16; i++)
            emit(instrImm(cpuIsaPkg::out, i, 0, 0));
        emit(instrImm(cpuIsaPkg::halt, 0, 0, 0));
    endtask

    task automatic buildAluProgram();
        cpuIsaPkg::opcodeT aluOps [4] = '{cpuIsaPkg::add, cpuIsaPkg::sub,
                                          cpuIsaPkg::andOp, cpuIsaPkg::orOp};
        clearImage();
        for (int i = 0; i < 16; i++) begin
            image[256 + i] = nextRandom(32);
            emit(instrImm(cpuIsaPkg::ld, i, 0, 256 + i));
        end
        for (int k = 0; k < 24; k++)
            emit(instrReg(aluOps[2'(nextRandom(2))], nextRandom(4), nextRandom(4), nextRandom(4)));
        for (int i = 0; i < 16; i++)
            emit(instrImm(cpuIsaPkg::out, i, 0, 0));
        emit(instrImm(cpuIsaPkg::halt, 0, 0, 0));
    endtask

    // Stores through R5 and absolute, then loads back
    task automatic buildMemProgram();
        clearImage();
        for (int i = 1; i <= 4; i++) begin
            image[256 + i] = nextRandom(32);
            emit(instrImm(cpuIsaPkg::ld, i, 0, 256 + i));
        end
        image[261] = 32'd320; // Base pointer
        emit(instrImm(cpuIsaPkg::ld, 5, 0, 261));
        emit(instrImm(cpuIsaPkg::st, 1, 5, 0));
        emit(instrImm(cpuIsaPkg::st, 2, 5, 5));
        emit(instrImm(cpuIsaPkg::st, 3, 5, -3)); // Negative offset
        emit(instrImm(cpuIsaPkg::st, 4, 0, 400));
        emit(instrImm(cpuIsaPkg::st, 2, 0, 401));
        emit(instrImm(cpuIsaPkg::ld, 6, 5, 0));
        emit(instrImm(cpuIsaPkg::ld, 7, 5, 5));
        emit(instrImm(cpuIsaPkg::ld, 8, 5, -3));
        emit(instrImm(cpuIsaPkg::ld, 9, 0, 400));
        emit(instrImm(cpuIsaPkg::ld, 10, 0, 401));
        for (int i = 6; i <= 10; i++)
            emit(instrImm(cpuIsaPkg::out, i, 0, 0));
        emit(instrImm(cpuIsaPkg::halt, 0, 0, 0));
    endtask

    task automatic loadImage();
        for (int a = 0; a < cpuIsaPkg::memWords; a++) begin
            @(posedge clk);
            #1;
            hostWrEn = 1'b1;
            hostAddr = 9'(a);
            hostData = image[a];
        end
        @(posedge clk);
        #1 hostWrEn = 1'b0;
    endtask

    // Start pulse, then count running cycles until halted rises
    task automatic runOnce(input int modelCycles);
        int cycles;
        cycles = 0;
        assert (halted === 1'b1)
            else finishWithFailure("The core was not halted before start");
        started = 1'b1;
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        @(negedge clk);
        while (!halted) begin
            cycles++;
            @(negedge clk);
        end
        assert (cycles == modelCycles)
            else finishWithFailure($sformatf("FAIL %0t: halted after %0d cycles, expected %0d",
                                             $time, cycles, modelCycles));
        assert (outIdx == expQueue.size())
            else finishWithFailure($sformatf("FAIL %0t: %0d out values seen, expected %0d",
                                             $time, outIdx, expQueue.size()));
    endtask

    task automatic checkMemory();
        for (int a = 0; a < cpuIsaPkg::memWords; a++) begin
            @(posedge clk);
            #1 hostAddr = 9'(a);
            @(negedge clk);
            assert (hostRdData === modelMem[a])
                else finishWithFailure($sformatf("FAIL %0t: mem[%0d] is 0x%08h, expected 0x%08h",
                                                 $time, a, hostRdData, modelMem[a]));
        end
    endtask

    task automatic runProgram(input int runs);
        int modelCycles;
        foreach (image[a])
            modelMem[a] = image[a];
        modelCycles = refRun();
        cycleLimit += runs * (modelCycles + 100) + 2 * cpuIsaPkg::memWords + 20;
        loadImage();
        repeat (runs) begin // A rerun starts again at word 0
            foreach (expOuts[i])
                expQueue.push_back(expOuts[i]);
            runOnce(modelCycles);
        end
        checkMemory();
    endtask

    initial begin
        rstN = 1'b0;
        start = 1'b0;
        hostWrEn = 1'b0;
        hostAddr = '0;
        hostData = '0;
        repeat (16) @(posedge clk);
        #1 rstN = 1'b1;
        assert (halted === 1'b1)
            else finishWithFailure($sformatf("FAIL %0t: halted is %b after reset, expected 1",
                                             $time, halted));
        buildAddiProgram();
        runProgram(1);
        buildAluProgram();
        runProgram(1);
        buildMemProgram();
        runProgram(2);
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: build.f
+incdir+verification
hdl/cpuIsaPkg.sv
hdl/cpuCtrlPkg.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/memoryInterface.sv
hdl/cpuTop.sv
verification/cpuTb.sv

// File: Makefile
# Verilator build and run for the load/store bus core testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0

SRCS := $(wildcard hdl/*.sv) $(wildcard verification/*.sv) $(wildcard verification/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
